//--- mpls_egress.f
common/mpls_router_pkg.sv
logic/mpls_egress_demux.sv
egress_buffer/egress_packet_buffer.sv
egress_buffer/egress_width_adapt.sv
logic/mpls_egress_port_array_adapt.sv
logic/mpls_egress.sv
verif/tb_clock_gen.sv
verif/mpls_egress_tb.sv

//--- verif/mpls_egress_tb.sv
/* Byte-level model per port; tests drain every port before they end, so buffer
   occupancy can be derived from port handshakes. Random data from a 16-bit LFSR. */

module mpls_egress_tb
    import mpls_router_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD_NS = 4;
    localparam int MAX_BEATS     = 8;
    localparam int ROUTE_PKTS    = 24;
    localparam int BP_PKTS       = 24;
    localparam int WIDTH_BEATS   = 16 * 4 * 2;
    localparam int OVF_BEATS     = 61 + 7 * 3;
    localparam int TOTAL_BEATS   = (ROUTE_PKTS + BP_PKTS) * MAX_BEATS + WIDTH_BEATS + OVF_BEATS;
    localparam int EXP_SLOTS     = 4096;
    localparam int LEN_SLOTS     = 256;

    logic clk;
    logic rst;
    logic rst_d;

    logic                              egr_tvalid;
    logic [EGR_BUS_WIDTH-1:0]          egr_tdata;
    logic [EGR_BUS_BYTES-1:0]          egr_tkeep;
    logic                              egr_tlast;
    logic [NUM_EGR_PHYS_PORTS_LOG-1:0] egr_tuser;

    logic [1:0]       port_16b_tvalid;
    logic [1:0]       port_16b_tready;
    logic [1:0][15:0] port_16b_tdata;
    logic [1:0][1:0]  port_16b_tkeep;
    logic [1:0]       port_16b_tlast;
    logic [1:0]       port_32b_tvalid;
    logic [1:0]       port_32b_tready;
    logic [1:0][31:0] port_32b_tdata;
    logic [1:0][3:0]  port_32b_tkeep;
    logic [1:0]       port_32b_tlast;
    logic [1:0]       buf_overflow_16b;
    logic [1:0]       buf_overflow_32b;

    // All four ports seen by global index, 16-bit ports zero-extended
    logic [NUM_EGR_PHYS_PORTS-1:0] p_vld;
    logic [NUM_EGR_PHYS_PORTS-1:0] p_rdy;
    logic [NUM_EGR_PHYS_PORTS-1:0] p_last;
    logic [NUM_EGR_PHYS_PORTS-1:0] p_ovf;
    logic [31:0]                   p_data [NUM_EGR_PHYS_PORTS];
    logic [3:0]                    p_keep [NUM_EGR_PHYS_PORTS];

    assign p_vld  = {port_32b_tvalid, port_16b_tvalid};
    assign p_last = {port_32b_tlast, port_16b_tlast};
    assign p_ovf  = {buf_overflow_32b, buf_overflow_16b};
    assign p_data[0] = {16'h0, port_16b_tdata[0]};
    assign p_data[1] = {16'h0, port_16b_tdata[1]};
    assign p_data[2] = port_32b_tdata[0];
    assign p_data[3] = port_32b_tdata[1];
    assign p_keep[0] = {2'b00, port_16b_tkeep[0]};
    assign p_keep[1] = {2'b00, port_16b_tkeep[1]};
    assign p_keep[2] = port_32b_tkeep[0];
    assign p_keep[3] = port_32b_tkeep[1];
    assign port_16b_tready = p_rdy[INDEX_16B_START +: NUM_16B_EGR_PHYS_PORTS];
    assign port_32b_tready = p_rdy[INDEX_32B_START +: NUM_32B_EGR_PHYS_PORTS];

    tb_clock_gen #(
        .PERIOD_NS    (CLK_PERIOD_NS),
        .RESET_CYCLES (4)
    ) clock_gen_inst (
        .clk (clk),
        .rst (rst)
    );

    mpls_egress mpls_egress_inst (.*);

    ////////////////////
    // Reference model
    ////////////////////

    logic [7:0] exp_mem [NUM_EGR_PHYS_PORTS][EXP_SLOTS];
    int         exp_len [NUM_EGR_PHYS_PORTS][LEN_SLOTS];
    int exp_hd [NUM_EGR_PHYS_PORTS];
    int exp_tl [NUM_EGR_PHYS_PORTS];
    int len_hd [NUM_EGR_PHYS_PORTS];
    int len_tl [NUM_EGR_PHYS_PORTS];
    int pkt_used [NUM_EGR_PHYS_PORTS];
    // Admitted beats whose last word has not left the port yet
    int pend [NUM_EGR_PHYS_PORTS];
    int exp_drops [NUM_EGR_PHYS_PORTS];
    int ovf_cnt [NUM_EGR_PHYS_PORTS];

    logic [15:0] stim_rng;
    logic [15:0] rdy_rng;
    logic        rand_ready;
    logic [3:0]  ready_mask;
    int errors;
    int errs_at_start;
    int tests_run;
    int tests_failed;

    bit          stalled   [NUM_EGR_PHYS_PORTS];
    logic [31:0] prev_data [NUM_EGR_PHYS_PORTS];
    logic [3:0]  prev_keep [NUM_EGR_PHYS_PORTS];
    logic        prev_last [NUM_EGR_PHYS_PORTS];

    // Taps 16, 14, 13, 11
    function automatic logic [31:0] lfsr_take(inout logic [15:0] state, input int nbits);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            fb    = state[15] ^ state[13] ^ state[12] ^ state[10];
            state = {state[14:0], fb};
            val   = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic string sig_name(input int p, input string field);
        if (p < INDEX_32B_START) return $sformatf("port_16b_%s[%0d]", field, p);
        return $sformatf("port_32b_%s[%0d]", field, p - INDEX_32B_START);
    endfunction

    function automatic string ovf_name(input int p);
        if (p < INDEX_32B_START) return $sformatf("buf_overflow_16b[%0d]", p);
        return $sformatf("buf_overflow_32b[%0d]", p - INDEX_32B_START);
    endfunction

    function automatic bit all_drained();
        for (int p = 0; p < NUM_EGR_PHYS_PORTS; p++) begin
            if (len_hd[p] != len_tl[p]) return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp) else begin
            errors++;
            $display("FAILED t=%0t %s expected %0h got %0h", $time, name, exp, got);
        end
    endtask

    // One port word against the head of the model queue
    task automatic check_word(input int p);
        int w;
        int r;
        int k;
        w = (p < INDEX_32B_START) ? 2 : 4;
        r = exp_len[p][len_hd[p] % LEN_SLOTS] - pkt_used[p];
        k = (r < w) ? r : w;
        check_value(sig_name(p, "tkeep"), (1 << k) - 1, p_keep[p]);
        check_value(sig_name(p, "tlast"), r <= w, p_last[p]);
        for (int i = 0; i < k; i++) begin
            check_value(sig_name(p, "tdata"), exp_mem[p][exp_hd[p] % EXP_SLOTS],
                        p_data[p][8*i +: 8]);
            exp_hd[p]++;
        end
        pkt_used[p] += k;
        // A 64-bit beat leaves the buffer once its last word is taken
        if (pkt_used[p] % EGR_BUS_BYTES == 0 || r <= w) pend[p]--;
        if (r <= w) begin
            len_hd[p]++;
            pkt_used[p] = 0;
        end
    endtask

    ////////////////////
    // Output checks
    ////////////////////

    always @(posedge clk) begin
        rst_d <= rst;
        for (int p = 0; p < NUM_EGR_PHYS_PORTS; p++) begin
            if (rst_d) begin
                check_value(sig_name(p, "tvalid"), 0, p_vld[p]);
                check_value(ovf_name(p), 0, p_ovf[p]);
            end else if (!rst) begin
                if (p_ovf[p]) ovf_cnt[p]++;
                // Word held under back-pressure must not change
                if (stalled[p]) begin
                    check_value(sig_name(p, "tvalid"), 1, p_vld[p]);
                    check_value(sig_name(p, "tdata"), prev_data[p], p_data[p]);
                    check_value(sig_name(p, "tkeep"), prev_keep[p], p_keep[p]);
                    check_value(sig_name(p, "tlast"), prev_last[p], p_last[p]);
                end
                assert (!(p_vld[p] && len_hd[p] == len_tl[p])) else begin
                    errors++;
                    $display("Port %0d raised tvalid at %0t with no packet expected", p, $time);
                end
                if (p_vld[p] && p_rdy[p] && len_hd[p] != len_tl[p]) check_word(p);
                stalled[p]   = p_vld[p] && !p_rdy[p];
                prev_data[p] = p_data[p];
                prev_keep[p] = p_keep[p];
                prev_last[p] = p_last[p];
            end
        end
    end

    always @(posedge clk) begin
        if (rand_ready) begin
            p_rdy <= 4'(lfsr_take(rdy_rng, 4));
        end else begin
            p_rdy <= ready_mask;
        end
    end

    ////////////////////
    // Stimulus
    ////////////////////

    // exact: port tready held low, so the adapter holds one beat and reads nothing more
    task automatic send_packet(input int port, input int nbytes, input bit exact);
        int          nbeats;
        int          occ;
        bit          admit;
        logic [7:0]  pkt [MTU_BYTES];
        logic [63:0] data;
        logic [7:0]  keep;
        nbeats = (nbytes + EGR_BUS_BYTES - 1) / EGR_BUS_BYTES;
        if (!exact) begin
            while (pend[port] + nbeats > BUF_DEPTH_BEATS) @(posedge clk);
        end
        occ   = (exact && pend[port] > 0) ? pend[port] - 1 : pend[port];
        admit = (nbeats <= BUF_DEPTH_BEATS - occ);
        for (int i = 0; i < nbytes; i++) begin
            pkt[i] = 8'(lfsr_take(stim_rng, 8));
        end
        if (admit) begin
            for (int i = 0; i < nbytes; i++) begin
                exp_mem[port][exp_tl[port] % EXP_SLOTS] = pkt[i];
                exp_tl[port]++;
            end
            exp_len[port][len_tl[port] % LEN_SLOTS] = nbytes;
            len_tl[port]++;
            pend[port] += nbeats;
        end else begin
            exp_drops[port]++;
        end
        for (int b = 0; b < nbeats; b++) begin
            data = '0;
            keep = '0;
            for (int i = 0; i < EGR_BUS_BYTES; i++) begin
                if (b * EGR_BUS_BYTES + i < nbytes) begin
                    data[8*i +: 8] = pkt[b * EGR_BUS_BYTES + i];
                    keep[i]        = 1'b1;
                end
            end
            @(posedge clk);
            egr_tvalid <= 1'b1;
            egr_tdata  <= data;
            egr_tkeep  <= keep;
            egr_tlast  <= (b == nbeats - 1);
            egr_tuser  <= NUM_EGR_PHYS_PORTS_LOG'(port);
        end
        @(posedge clk);
        egr_tvalid <= 1'b0;
    endtask

    task automatic finish_test(input string name);
        int new_errs;
        while (!all_drained()) @(posedge clk);
        repeat (8) @(posedge clk);
        for (int p = 0; p < NUM_EGR_PHYS_PORTS; p++) begin
            check_value({ovf_name(p), " pulse count"}, exp_drops[p], ovf_cnt[p]);
        end
        new_errs = errors - errs_at_start;
        errs_at_start = errors;
        tests_run++;
        if (new_errs != 0) tests_failed++;
        $display("test %-12s %s", name,
                 (new_errs == 0) ? "ok" : $sformatf("failed with %0d errors", new_errs));
    endtask

    initial begin
        int ovf_len [7];
        egr_tvalid = 1'b0;
        egr_tdata  = '0;
        egr_tkeep  = '0;
        egr_tlast  = 1'b0;
        egr_tuser  = '0;
        p_rdy      = '1;
        rst_d      = 1'b0;
        rand_ready = 1'b0;
        ready_mask = '1;
        stim_rng   = 16'd39;
        rdy_rng    = 16'd39;
        ovf_len    = '{96, 92, 96, 90, 48, 30, 21};

        wait (!rst);
        repeat (2) @(posedge clk);
        finish_test("reset");

        repeat (ROUTE_PKTS) begin
            send_packet(lfsr_take(stim_rng, 2), 1 + lfsr_take(stim_rng, 6), 1'b0);
        end
        finish_test("routing");

        // Every final byte count on every port
        for (int n = 1; n <= 16; n++) begin
            for (int p = 0; p < NUM_EGR_PHYS_PORTS; p++) begin
                send_packet(p, n, 1'b0);
            end
        end
        finish_test("width");

        rand_ready = 1'b1;
        repeat (BP_PKTS) begin
            send_packet(lfsr_take(stim_rng, 2), 1 + lfsr_take(stim_rng, 6), 1'b0);
        end
        finish_test("backpressure");
        rand_ready = 1'b0;

        // Port 1 stalled, port 2 keeps flowing in between
        ready_mask = 4'b1101;
        for (int i = 0; i < 7; i++) begin
            send_packet(1, ovf_len[i], 1'b1);
            send_packet(2, 12 + i, 1'b0);
            repeat (4) @(posedge clk);
        end
        repeat (20) @(posedge clk);
        ready_mask = '1;
        finish_test("overflow");

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // Watchdog, 20 cycles per input beat of all tests
    initial begin
        #(TOTAL_BEATS * 20 * CLK_PERIOD_NS);
        $display("Timeout: tests did not finish within %0d cycles", TOTAL_BEATS * 20);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- verif/tb_clock_gen.sv
/* Free-running clock; rst is high from time zero and drops on a rising edge. */

module tb_clock_gen #(
    parameter real PERIOD_NS    = 4.0,
    parameter int  RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    // Released like any other synchronous input
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

//--- logic/mpls_egress.sv
/* Egress subsystem on one clock; the input bus has no ready and is never stalled.
   Full buffers drop whole packets and flag buf_overflow, there is no queueing. */

module mpls_egress
    import mpls_router_pkg::*;
(
    input  logic                                        clk,
    input  logic                                        rst,

    // Egress bus, egr_tuser is the global port index
    input  logic                                        egr_tvalid,
    input  logic [EGR_BUS_WIDTH-1:0]                    egr_tdata,
    input  logic [EGR_BUS_BYTES-1:0]                    egr_tkeep,
    input  logic                                        egr_tlast,
    input  logic [NUM_EGR_PHYS_PORTS_LOG-1:0]           egr_tuser,

    // 16-bit ports
    output logic [NUM_16B_EGR_PHYS_PORTS-1:0]           port_16b_tvalid,
    input  logic [NUM_16B_EGR_PHYS_PORTS-1:0]           port_16b_tready,
    output logic [NUM_16B_EGR_PHYS_PORTS-1:0][15:0]     port_16b_tdata,
    output logic [NUM_16B_EGR_PHYS_PORTS-1:0][1:0]      port_16b_tkeep,
    output logic [NUM_16B_EGR_PHYS_PORTS-1:0]           port_16b_tlast,

    // 32-bit ports
    output logic [NUM_32B_EGR_PHYS_PORTS-1:0]           port_32b_tvalid,
    input  logic [NUM_32B_EGR_PHYS_PORTS-1:0]           port_32b_tready,
    output logic [NUM_32B_EGR_PHYS_PORTS-1:0][31:0]     port_32b_tdata,
    output logic [NUM_32B_EGR_PHYS_PORTS-1:0][3:0]      port_32b_tkeep,
    output logic [NUM_32B_EGR_PHYS_PORTS-1:0]           port_32b_tlast,

    // Congestion drops, one pulse per dropped packet
    output logic [NUM_16B_EGR_PHYS_PORTS-1:0]           buf_overflow_16b,
    output logic [NUM_32B_EGR_PHYS_PORTS-1:0]           buf_overflow_32b
);

    logic [NUM_EGR_PHYS_PORTS-1:0] demux_tvalid;
    logic [EGR_BUS_WIDTH-1:0]      demux_tdata;
    logic [EGR_BUS_BYTES-1:0]      demux_tkeep;
    logic                          demux_tlast;

    ////////////////////
    // Demux
    ////////////////////

    mpls_egress_demux demux_inst (
        .clk          (clk),
        .rst          (rst),
        .egr_tvalid   (egr_tvalid),
        .egr_tdata    (egr_tdata),
        .egr_tkeep    (egr_tkeep),
        .egr_tlast    (egr_tlast),
        .egr_tuser    (egr_tuser),
        .demux_tvalid (demux_tvalid),
        .demux_tdata  (demux_tdata),
        .demux_tkeep  (demux_tkeep),
        .demux_tlast  (demux_tlast)
    );

    ////////////////////
    // Port arrays
    ////////////////////

    mpls_egress_port_array_adapt #(
        .NUM_PORTS (NUM_16B_EGR_PHYS_PORTS),
        .OUT_BYTES (2)
    ) array_16b_inst (
        .clk          (clk),
        .rst          (rst),
        .demux_tvalid (demux_tvalid[INDEX_16B_START +: NUM_16B_EGR_PHYS_PORTS]),
        .demux_tdata  (demux_tdata),
        .demux_tkeep  (demux_tkeep),
        .demux_tlast  (demux_tlast),
        .port_tvalid  (port_16b_tvalid),
        .port_tready  (port_16b_tready),
        .port_tdata   (port_16b_tdata),
        .port_tkeep   (port_16b_tkeep),
        .port_tlast   (port_16b_tlast),
        .buf_overflow (buf_overflow_16b)
    );

    mpls_egress_port_array_adapt #(
        .NUM_PORTS (NUM_32B_EGR_PHYS_PORTS),
        .OUT_BYTES (4)
    ) array_32b_inst (
        .clk          (clk),
        .rst          (rst),
        .demux_tvalid (demux_tvalid[INDEX_32B_START +: NUM_32B_EGR_PHYS_PORTS]),
        .demux_tdata  (demux_tdata),
        .demux_tkeep  (demux_tkeep),
        .demux_tlast  (demux_tlast),
        .port_tvalid  (port_32b_tvalid),
        .port_tready  (port_32b_tready),
        .port_tdata   (port_32b_tdata),
        .port_tkeep   (port_32b_tkeep),
        .port_tlast   (port_32b_tlast),
        .buf_overflow (buf_overflow_32b)
    );

endmodule

//--- logic/mpls_egress_port_array_adapt.sv
/* All ports of one width; each has its own buffer and width adapter.
   Payload from the demux is shared, only the valid bit is per port. */

module mpls_egress_port_array_adapt
    import mpls_router_pkg::*;
#(
    parameter int NUM_PORTS = 2,
    parameter int OUT_BYTES = 2
) (
    input  logic                                    clk,
    input  logic                                    rst,

    input  logic [NUM_PORTS-1:0]                    demux_tvalid,
    input  logic [EGR_BUS_WIDTH-1:0]                demux_tdata,
    input  logic [EGR_BUS_BYTES-1:0]                demux_tkeep,
    input  logic                                    demux_tlast,

    output logic [NUM_PORTS-1:0]                    port_tvalid,
    input  logic [NUM_PORTS-1:0]                    port_tready,
    output logic [NUM_PORTS-1:0][8*OUT_BYTES-1:0]   port_tdata,
    output logic [NUM_PORTS-1:0][OUT_BYTES-1:0]     port_tkeep,
    output logic [NUM_PORTS-1:0]                    port_tlast,

    output logic [NUM_PORTS-1:0]                    buf_overflow
);

    // Buffer to adapter links
    logic [NUM_PORTS-1:0]                    buf_tvalid;
    logic [NUM_PORTS-1:0]                    buf_tready;
    logic [NUM_PORTS-1:0][EGR_BUS_WIDTH-1:0] buf_tdata;
    logic [NUM_PORTS-1:0][EGR_BUS_BYTES-1:0] buf_tkeep;
    logic [NUM_PORTS-1:0]                    buf_tlast;

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        egress_packet_buffer buf_inst (
            .clk          (clk),
            .rst          (rst),
            .wr_tvalid    (demux_tvalid[p]),
            .wr_tdata     (demux_tdata),
            .wr_tkeep     (demux_tkeep),
            .wr_tlast     (demux_tlast),
            .buf_tvalid   (buf_tvalid[p]),
            .buf_tready   (buf_tready[p]),
            .buf_tdata    (buf_tdata[p]),
            .buf_tkeep    (buf_tkeep[p]),
            .buf_tlast    (buf_tlast[p]),
            .buf_overflow (buf_overflow[p])
        );

        egress_width_adapt #(
            .OUT_BYTES (OUT_BYTES)
        ) adapt_inst (
            .clk        (clk),
            .rst        (rst),
            .in_tvalid  (buf_tvalid[p]),
            .in_tready  (buf_tready[p]),
            .in_tdata   (buf_tdata[p]),
            .in_tkeep   (buf_tkeep[p]),
            .in_tlast   (buf_tlast[p]),
            .out_tvalid (port_tvalid[p]),
            .out_tready (port_tready[p]),
            .out_tdata  (port_tdata[p]),
            .out_tkeep  (port_tkeep[p]),
            .out_tlast  (port_tlast[p])
        );
    end

endmodule

//--- egress_buffer/egress_width_adapt.sv
/* Splits 8-byte beats into OUT_BYTES words (2 or 4); keep must be contiguous from byte 0.
   Only the final beat of a packet may be partial. */

module egress_width_adapt #(
    parameter int OUT_BYTES = 2
) (
    input  logic                   clk,
    input  logic                   rst,

    // Wide side from the packet buffer
    input  logic                   in_tvalid,
    output logic                   in_tready,
    input  logic [63:0]            in_tdata,
    input  logic [7:0]             in_tkeep,
    input  logic                   in_tlast,

    // Port side
    output logic                   out_tvalid,
    input  logic                   out_tready,
    output logic [8*OUT_BYTES-1:0] out_tdata,
    output logic [OUT_BYTES-1:0]   out_tkeep,
    output logic                   out_tlast
);

    localparam int NUM_LANES = 8 / OUT_BYTES;

    ////////////////////
    // Held beat
    ////////////////////

    logic [63:0] data_q;
    logic [7:0]  keep_q;
    logic        last_q;
    logic        held;

    logic [$clog2(NUM_LANES)-1:0] lane;

    // A lane group is used when its first byte is kept
    logic [NUM_LANES-1:0] lane_used;
    logic [NUM_LANES-1:0] more_lanes;
    logic                 last_group;

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            lane_used[i] = keep_q[i*OUT_BYTES];
        end
    end

    // Bit i says some later group still has data
    assign more_lanes = lane_used >> 1;
    assign last_group = !more_lanes[lane];

    assign out_tvalid = held;
    assign out_tdata  = data_q[lane*8*OUT_BYTES +: 8*OUT_BYTES];
    assign out_tkeep  = keep_q[lane*OUT_BYTES +: OUT_BYTES];
    assign out_tlast  = last_q && last_group;

    // Take the next beat on the same cycle the last group leaves
    assign in_tready = !held || (out_tready && last_group);

    always_ff @(posedge clk) begin
        if (rst) begin
            held <= 1'b0;
            lane <= '0;
        end else if (in_tvalid && in_tready) begin
            held <= 1'b1;
            lane <= '0;
        end else if (held && out_tready) begin
            if (last_group) begin
                held <= 1'b0;
            end else begin
                lane <= lane + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_tvalid && in_tready) begin
            data_q <= in_tdata;
            keep_q <= in_tkeep;
            last_q <= in_tlast;
        end
    end

endmodule

//--- egress_buffer/egress_packet_buffer.sv
/* Store-and-forward buffer; only packets whose tlast was written can be read.
   A packet that runs into unread data is dropped whole and buf_overflow pulses once. */

module egress_packet_buffer
    import mpls_router_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,

    // Write side, no ready
    input  logic                     wr_tvalid,
    input  logic [EGR_BUS_WIDTH-1:0] wr_tdata,
    input  logic [EGR_BUS_BYTES-1:0] wr_tkeep,
    input  logic                     wr_tlast,

    // Read side
    output logic                     buf_tvalid,
    input  logic                     buf_tready,
    output logic [EGR_BUS_WIDTH-1:0] buf_tdata,
    output logic [EGR_BUS_BYTES-1:0] buf_tkeep,
    output logic                     buf_tlast,

    output logic                     buf_overflow
);

    ////////////////////
    // Storage
    ////////////////////

    logic [EGR_BUS_WIDTH-1:0] data_mem [BUF_DEPTH_BEATS];
    logic [EGR_BUS_BYTES-1:0] keep_mem [BUF_DEPTH_BEATS];
    logic                     last_mem [BUF_DEPTH_BEATS];

    // Pointers carry one wrap bit above the address
    logic [BUF_ADDR_WIDTH:0] wr_ptr;
    logic [BUF_ADDR_WIDTH:0] commit_ptr;
    logic [BUF_ADDR_WIDTH:0] rd_ptr;

    // Rest of a dropped packet is skipped up to its tlast
    logic discard;

    logic full;
    logic wr_en;
    logic rd_en;

    // In-flight beats count against the space too
    assign full  = (wr_ptr - rd_ptr) == (BUF_ADDR_WIDTH + 1)'(BUF_DEPTH_BEATS);
    assign wr_en = wr_tvalid && !discard && !full;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            data_mem[wr_ptr[BUF_ADDR_WIDTH-1:0]] <= wr_tdata;
            keep_mem[wr_ptr[BUF_ADDR_WIDTH-1:0]] <= wr_tkeep;
            last_mem[wr_ptr[BUF_ADDR_WIDTH-1:0]] <= wr_tlast;
        end
    end

    ////////////////////
    // Write control
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr       <= '0;
            commit_ptr   <= '0;
            discard      <= 1'b0;
            buf_overflow <= 1'b0;
        end else begin
            buf_overflow <= 1'b0;
            if (wr_tvalid) begin
                if (discard) begin
                    if (wr_tlast) begin
                        discard <= 1'b0;
                    end
                end else if (full) begin
                    // Drop decided here, back to last packet boundary
                    wr_ptr       <= commit_ptr;
                    discard      <= !wr_tlast;
                    buf_overflow <= 1'b1;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                    if (wr_tlast) begin
                        commit_ptr <= wr_ptr + 1'b1;
                    end
                end
            end
        end
    end

    ////////////////////
    // Read side
    ////////////////////

    // Committed beats only, visible the cycle after tlast
    assign buf_tvalid = (rd_ptr != commit_ptr);
    assign rd_en      = buf_tvalid && buf_tready;

    // Slot under rd_ptr is never rewritten until read
    assign buf_tdata = data_mem[rd_ptr[BUF_ADDR_WIDTH-1:0]];
    assign buf_tkeep = keep_mem[rd_ptr[BUF_ADDR_WIDTH-1:0]];
    assign buf_tlast = last_mem[rd_ptr[BUF_ADDR_WIDTH-1:0]];

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
        end else if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

endmodule

//--- logic/mpls_egress_demux.sv
/* One-cycle registered demux; the input has no ready, so every valid beat is taken.
   egr_tuser must hold a port index below NUM_EGR_PHYS_PORTS. */

module mpls_egress_demux
    import mpls_router_pkg::*;
(
    input  logic                              clk,
    input  logic                              rst,

    // Egress bus from the forwarding pipeline
    input  logic                              egr_tvalid,
    input  logic [EGR_BUS_WIDTH-1:0]          egr_tdata,
    input  logic [EGR_BUS_BYTES-1:0]          egr_tkeep,
    input  logic                              egr_tlast,
    input  logic [NUM_EGR_PHYS_PORTS_LOG-1:0] egr_tuser,

    // One valid per port, payload shared
    output logic [NUM_EGR_PHYS_PORTS-1:0]     demux_tvalid,
    output logic [EGR_BUS_WIDTH-1:0]          demux_tdata,
    output logic [EGR_BUS_BYTES-1:0]          demux_tkeep,
    output logic                              demux_tlast
);

    ////////////////////
    // Port select
    ////////////////////

    // One-hot valid from the user index
    always_ff @(posedge clk) begin
        if (rst) begin
            demux_tvalid <= '0;
        end else begin
            for (int i = 0; i < NUM_EGR_PHYS_PORTS; i++) begin
                demux_tvalid[i] <= egr_tvalid && (egr_tuser == NUM_EGR_PHYS_PORTS_LOG'(i));
            end
        end
    end

    ////////////////////
    // Payload
    ////////////////////

    // Only captured on a valid beat
    always_ff @(posedge clk) begin
        if (egr_tvalid) begin
            demux_tdata <= egr_tdata;
            demux_tkeep <= egr_tkeep;
            demux_tlast <= egr_tlast;
        end
    end

endmodule

//--- common/mpls_router_pkg.sv
/* Fixed egress configuration: two 16-bit and two 32-bit ports on one 64-bit bus.
   Buffers hold one MTU of 64-bit beats, so larger packets are always dropped. */

package mpls_router_pkg;

    ////////////////////
    // Egress bus
    ////////////////////

    localparam int EGR_BUS_BYTES = 8;
    localparam int EGR_BUS_WIDTH = 8 * EGR_BUS_BYTES;

    ////////////////////
    // Port arrays
    ////////////////////

    // 8-bit and 64-bit arrays are not built
    localparam int NUM_16B_EGR_PHYS_PORTS = 2;
    localparam int NUM_32B_EGR_PHYS_PORTS = 2;

    localparam int NUM_EGR_PHYS_PORTS = NUM_16B_EGR_PHYS_PORTS + NUM_32B_EGR_PHYS_PORTS;

    // Width of egr_tuser
    localparam int NUM_EGR_PHYS_PORTS_LOG = $clog2(NUM_EGR_PHYS_PORTS);

    // Global port index map, arrays in order of width
    localparam int INDEX_16B_START = 0;
    localparam int INDEX_32B_START = INDEX_16B_START + NUM_16B_EGR_PHYS_PORTS;

    ////////////////////
    // Packet buffers
    ////////////////////

    localparam int MTU_BYTES = 256;

    // One MTU worth of full beats per port
    localparam int BUF_DEPTH_BEATS = MTU_BYTES / EGR_BUS_BYTES;
    localparam int BUF_ADDR_WIDTH  = $clog2(BUF_DEPTH_BEATS);

endpackage
